/* logic/csr_pkg.sv */
package csr_pkg;

   localparam int CSR_NUM_W = 14;
   localparam int DATA_W    = 32;

   // Architectural register numbers
   localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
   localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
   localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
   localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
   localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
   localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
   localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
   localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
   localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
   localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
   localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
   localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
   localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
   localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
   localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

   // Bit 10 of LIE is reserved
   localparam logic [12:0] LIE_MASK = 13'h1bff;

   localparam logic [DATA_W-1:0] TIMER_IDLE = 32'hffff_ffff;
   localparam logic [DATA_W-1:0] CRMD_RESET = 32'h0000_0008;

   localparam int N_SAVE = 4;

   // Single bit fields
   localparam int TCFG_EN_BIT     = 0;
   localparam int TCFG_PERIOD_BIT = 1;
   localparam int TICLR_CLR_BIT   = 0;

   typedef struct packed {
      logic                 re;
      logic [CSR_NUM_W-1:0] num;
      logic                 we;
      logic [DATA_W-1:0]    wmask;
      logic [DATA_W-1:0]    wvalue;
   } csr_access_t;

   typedef struct packed {
      logic [1:0]        crmd_datm;
      logic [1:0]        crmd_datf;
      logic              crmd_pg;
      logic              crmd_da;
      logic              crmd_ie;
      logic [1:0]        crmd_plv;
      logic              prmd_pie;
      logic [1:0]        prmd_pplv;
      logic [DATA_W-1:0] era;
      logic [DATA_W-1:0] badv;
      logic [25:0]       eentry_va;
      logic [5:0]        ecode;
      logic [8:0]        esubcode;
   } exc_csrs_t;

   typedef struct packed {
      logic [12:0]       lie;
      logic [12:0]       is;
      logic [29:0]       tcfg_initval;
      logic              tcfg_periodic;
      logic              tcfg_en;
      logic [DATA_W-1:0] tval;
   } timer_csrs_t;

   function automatic logic [DATA_W-1:0] masked_merge(
      input logic [DATA_W-1:0] old_value,
      input logic [DATA_W-1:0] wvalue,
      input logic [DATA_W-1:0] wmask
   );
      return (wmask & wvalue) | (~wmask & old_value);
   endfunction

endpackage

/* logic/exc_pkg.sv */
package exc_pkg;

   // Address error codes
   localparam logic [5:0] ECODE_ADE = 6'h08;
   localparam logic [5:0] ECODE_ALE = 6'h09;

   // Fetch side ADE
   localparam logic [8:0] ESUB_ADEF = 9'd0;

   typedef struct packed {
      logic                       ex;
      logic                       ertn;
      logic [csr_pkg::DATA_W-1:0] pc;
      logic [csr_pkg::DATA_W-1:0] vaddr;
      logic [5:0]                 ecode;
      logic [8:0]                 esubcode;
   } exc_report_t;

endpackage

/* logic/exc_state.sv */
`timescale 1ns/100ps

module exc_state
   import csr_pkg::*, exc_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  csr_access_t       csr_req,
   input  exc_report_t       exc,
   output logic              crmd_ie,
   output logic [DATA_W-1:0] ex_entry,
   output logic [DATA_W-1:0] era,
   output exc_csrs_t         state
);

   logic [1:0]        crmd_plv;
   logic              crmd_ie_q;
   logic              crmd_da;
   logic              crmd_pg;
   logic [1:0]        crmd_datf;
   logic [1:0]        crmd_datm;
   logic [1:0]        prmd_pplv;
   logic              prmd_pie;
   logic [DATA_W-1:0] era_pc;
   logic [25:0]       eentry_va;
   logic [DATA_W-1:0] badv_vaddr;
   logic [5:0]        estat_ecode;
   logic [8:0]        estat_esubcode;

   logic              wr_crmd;
   logic              wr_prmd;
   logic              wr_era;
   logic              wr_eentry;
   logic [DATA_W-1:0] crmd_new;
   logic [DATA_W-1:0] prmd_new;
   logic [DATA_W-1:0] eentry_new;
   logic              addr_err;
   logic              fetch_err;

   assign wr_crmd   = csr_req.we && csr_req.num == CSR_CRMD;
   assign wr_prmd   = csr_req.we && csr_req.num == CSR_PRMD;
   assign wr_era    = csr_req.we && csr_req.num == CSR_ERA;
   assign wr_eentry = csr_req.we && csr_req.num == CSR_EENTRY;

   assign crmd_new = masked_merge({23'd0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                   crmd_ie_q, crmd_plv}, csr_req.wvalue, csr_req.wmask);
   assign prmd_new = masked_merge({29'd0, prmd_pie, prmd_pplv},
                                  csr_req.wvalue, csr_req.wmask);
   assign eentry_new = masked_merge({eentry_va, 6'd0}, csr_req.wvalue, csr_req.wmask);

   assign addr_err  = exc.ecode == ECODE_ADE || exc.ecode == ECODE_ALE;
   assign fetch_err = exc.ecode == ECODE_ADE && exc.esubcode == ESUB_ADEF;

   // Exception entry beats ertn, which beats software writes
   always_ff @(posedge clk) begin
      if (!resetn) begin
         {crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie_q, crmd_plv} <= CRMD_RESET[8:0];
         prmd_pplv <= 2'd0;
         prmd_pie  <= 1'b0;
      end else if (exc.ex) begin
         prmd_pplv <= crmd_plv;
         prmd_pie  <= crmd_ie_q;
         crmd_plv  <= 2'd0;
         crmd_ie_q <= 1'b0;
      end else if (exc.ertn) begin
         crmd_plv  <= prmd_pplv;
         crmd_ie_q <= prmd_pie;
      end else begin
         if (wr_crmd) begin
            {crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie_q, crmd_plv} <= crmd_new[8:0];
         end
         if (wr_prmd) begin
            {prmd_pie, prmd_pplv} <= prmd_new[2:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (exc.ex) begin
         era_pc         <= exc.pc;
         estat_ecode    <= exc.ecode;
         estat_esubcode <= exc.esubcode;
      end else if (wr_era) begin
         era_pc <= masked_merge(era_pc, csr_req.wvalue, csr_req.wmask);
      end

      if (wr_eentry && !exc.ex && !exc.ertn) begin
         eentry_va <= eentry_new[31:6];
      end

      // Fetch faults report the PC itself
      if (exc.ex && addr_err) begin
         badv_vaddr <= fetch_err ? exc.pc : exc.vaddr;
      end
   end

   assign crmd_ie  = crmd_ie_q;
   assign ex_entry = {eentry_va, 6'd0};
   assign era      = era_pc;

   assign state = '{
      crmd_datm: crmd_datm,
      crmd_datf: crmd_datf,
      crmd_pg:   crmd_pg,
      crmd_da:   crmd_da,
      crmd_ie:   crmd_ie_q,
      crmd_plv:  crmd_plv,
      prmd_pie:  prmd_pie,
      prmd_pplv: prmd_pplv,
      era:       era_pc,
      badv:      badv_vaddr,
      eentry_va: eentry_va,
      ecode:     estat_ecode,
      esubcode:  estat_esubcode
   };

endmodule

/* logic/int_timer.sv */
`timescale 1ns/100ps

module int_timer
   import csr_pkg::*;
(
   input  logic        clk,
   input  logic        resetn,
   input  csr_access_t csr_req,
   input  logic [7:0]  hw_int,
   input  logic        ipi_int,
   input  logic        crmd_ie,
   output logic        has_int,
   output timer_csrs_t state
);

   logic [12:0]       ecfg_lie;
   logic [1:0]        is_sw;
   logic [7:0]        is_hw;
   logic              is_timer;
   logic              is_ipi;
   logic [12:0]       is_vec;
   logic              tcfg_en;
   logic              tcfg_periodic;
   logic [29:0]       tcfg_initval;
   logic [DATA_W-1:0] timer_cnt;

   logic              wr_ecfg;
   logic              wr_estat;
   logic              wr_tcfg;
   logic              wr_ticlr;
   logic [DATA_W-1:0] ecfg_new;
   logic [DATA_W-1:0] estat_new;
   logic [DATA_W-1:0] tcfg_new;
   logic [DATA_W-1:0] ticlr_new;

   assign wr_ecfg  = csr_req.we && csr_req.num == CSR_ECFG;
   assign wr_estat = csr_req.we && csr_req.num == CSR_ESTAT;
   assign wr_tcfg  = csr_req.we && csr_req.num == CSR_TCFG;
   assign wr_ticlr = csr_req.we && csr_req.num == CSR_TICLR;

   assign ecfg_new  = masked_merge({19'd0, ecfg_lie}, csr_req.wvalue, csr_req.wmask);
   assign estat_new = masked_merge({30'd0, is_sw}, csr_req.wvalue, csr_req.wmask);
   assign tcfg_new  = masked_merge({tcfg_initval, tcfg_periodic, tcfg_en},
                                   csr_req.wvalue, csr_req.wmask);
   // TICLR is write-one-to-clear and holds no state
   assign ticlr_new = masked_merge('0, csr_req.wvalue, csr_req.wmask);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ecfg_lie <= 13'd0;
      end else if (wr_ecfg) begin
         ecfg_lie <= ecfg_new[12:0] & LIE_MASK;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         is_sw    <= 2'd0;
         is_hw    <= 8'd0;
         is_ipi   <= 1'b0;
         is_timer <= 1'b0;
      end else begin
         if (wr_estat) begin
            is_sw <= estat_new[1:0];
         end
         is_hw  <= hw_int;
         is_ipi <= ipi_int;
         // Expiry has priority over the clear
         if (timer_cnt == '0) begin
            is_timer <= 1'b1;
         end else if (wr_ticlr && ticlr_new[TICLR_CLR_BIT]) begin
            is_timer <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tcfg_en       <= 1'b0;
         tcfg_periodic <= 1'b0;
         tcfg_initval  <= 30'd0;
      end else if (wr_tcfg) begin
         tcfg_en       <= tcfg_new[TCFG_EN_BIT];
         tcfg_periodic <= tcfg_new[TCFG_PERIOD_BIT];
         tcfg_initval  <= tcfg_new[31:2];
      end
   end

   // One-shot mode runs past zero into the idle value and stops
   always_ff @(posedge clk) begin
      if (!resetn) begin
         timer_cnt <= TIMER_IDLE;
      end else if (wr_tcfg && tcfg_new[TCFG_EN_BIT]) begin
         timer_cnt <= {tcfg_new[31:2], 2'b00};
      end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
         if (timer_cnt == '0 && tcfg_periodic) begin
            timer_cnt <= {tcfg_initval, 2'b00};
         end else begin
            timer_cnt <= timer_cnt - 1'b1;
         end
      end
   end

   assign is_vec  = {is_ipi, is_timer, 1'b0, is_hw, is_sw};
   assign has_int = crmd_ie & (|(is_vec & ecfg_lie));

   assign state = '{
      lie:           ecfg_lie,
      is:            is_vec,
      tcfg_initval:  tcfg_initval,
      tcfg_periodic: tcfg_periodic,
      tcfg_en:       tcfg_en,
      tval:          timer_cnt
   };

endmodule

/* logic/csr_scratch.sv */
`timescale 1ns/100ps

module csr_scratch
   import csr_pkg::*;
(
   input  logic                          clk,
   input  logic                          resetn,
   input  csr_access_t                   csr_req,
   input  logic [DATA_W-1:0]             coreid,
   output logic [N_SAVE-1:0][DATA_W-1:0] save_words,
   output logic [DATA_W-1:0]             tid
);

   logic [N_SAVE-1:0][DATA_W-1:0] save_q;
   logic [DATA_W-1:0]             tid_q;

   // SAVE numbers are consecutive from SAVE0
   always_ff @(posedge clk) begin
      for (int i = 0; i < N_SAVE; i++) begin
         if (csr_req.we && csr_req.num == CSR_SAVE0 + CSR_NUM_W'(i)) begin
            save_q[i] <= masked_merge(save_q[i], csr_req.wvalue, csr_req.wmask);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tid_q <= coreid;
      end else if (csr_req.we && csr_req.num == CSR_TID) begin
         tid_q <= masked_merge(tid_q, csr_req.wvalue, csr_req.wmask);
      end
   end

   assign save_words = save_q;
   assign tid        = tid_q;

endmodule

/* logic/csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux
   import csr_pkg::*;
(
   input  csr_access_t                   csr_req,
   input  exc_csrs_t                     exc_st,
   input  timer_csrs_t                   tmr_st,
   input  logic [N_SAVE-1:0][DATA_W-1:0] save_words,
   input  logic [DATA_W-1:0]             tid,
   output logic [DATA_W-1:0]             csr_rvalue
);

   logic [DATA_W-1:0] crmd_word;
   logic [DATA_W-1:0] prmd_word;
   logic [DATA_W-1:0] ecfg_word;
   logic [DATA_W-1:0] estat_word;
   logic [DATA_W-1:0] eentry_word;
   logic [DATA_W-1:0] tcfg_word;

   assign crmd_word   = {23'd0, exc_st.crmd_datm, exc_st.crmd_datf, exc_st.crmd_pg,
                         exc_st.crmd_da, exc_st.crmd_ie, exc_st.crmd_plv};
   assign prmd_word   = {29'd0, exc_st.prmd_pie, exc_st.prmd_pplv};
   assign ecfg_word   = {19'd0, tmr_st.lie};
   // Codes from exc_state, pending bits from int_timer
   assign estat_word  = {1'b0, exc_st.esubcode, exc_st.ecode, 3'd0, tmr_st.is};
   assign eentry_word = {exc_st.eentry_va, 6'd0};
   assign tcfg_word   = {tmr_st.tcfg_initval, tmr_st.tcfg_periodic, tmr_st.tcfg_en};

   always_comb begin
      case (csr_req.num)
         CSR_CRMD:   csr_rvalue = crmd_word;
         CSR_PRMD:   csr_rvalue = prmd_word;
         CSR_ECFG:   csr_rvalue = ecfg_word;
         CSR_ESTAT:  csr_rvalue = estat_word;
         CSR_ERA:    csr_rvalue = exc_st.era;
         CSR_BADV:   csr_rvalue = exc_st.badv;
         CSR_EENTRY: csr_rvalue = eentry_word;
         CSR_SAVE0:  csr_rvalue = save_words[0];
         CSR_SAVE1:  csr_rvalue = save_words[1];
         CSR_SAVE2:  csr_rvalue = save_words[2];
         CSR_SAVE3:  csr_rvalue = save_words[3];
         CSR_TID:    csr_rvalue = tid;
         CSR_TCFG:   csr_rvalue = tcfg_word;
         CSR_TVAL:   csr_rvalue = tmr_st.tval;
         CSR_TICLR:  csr_rvalue = '0;
         default:    csr_rvalue = '0;
      endcase
   end

endmodule

/* logic/csr_top.sv */
`timescale 1ns/100ps

module csr_top
   import csr_pkg::*, exc_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  csr_access_t       csr_req,
   input  exc_report_t       exc,
   input  logic [7:0]        hw_int,
   input  logic              ipi_int,
   input  logic [DATA_W-1:0] coreid,
   output logic [DATA_W-1:0] csr_rvalue,
   output logic [DATA_W-1:0] ex_entry,
   output logic [DATA_W-1:0] era,
   output logic              has_int
);

   exc_csrs_t                        exc_st;
   timer_csrs_t                      tmr_st;
   logic                             crmd_ie;
   logic [N_SAVE-1:0][DATA_W-1:0]    save_words;
   logic [DATA_W-1:0]                tid;

   exc_state u_exc_state (
      .clk      (clk),
      .resetn   (resetn),
      .csr_req  (csr_req),
      .exc      (exc),
      .crmd_ie  (crmd_ie),
      .ex_entry (ex_entry),
      .era      (era),
      .state    (exc_st)
   );

   int_timer u_int_timer (
      .clk     (clk),
      .resetn  (resetn),
      .csr_req (csr_req),
      .hw_int  (hw_int),
      .ipi_int (ipi_int),
      .crmd_ie (crmd_ie),
      .has_int (has_int),
      .state   (tmr_st)
   );

   csr_scratch u_csr_scratch (
      .clk        (clk),
      .resetn     (resetn),
      .csr_req    (csr_req),
      .coreid     (coreid),
      .save_words (save_words),
      .tid        (tid)
   );

   csr_read_mux u_csr_read_mux (
      .csr_req    (csr_req),
      .exc_st     (exc_st),
      .tmr_st     (tmr_st),
      .save_words (save_words),
      .tid        (tid),
      .csr_rvalue (csr_rvalue)
   );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
   parameter real PERIOD       = 4.0,
   parameter int  RESET_CYCLES = 5
) (
   output logic clk,
   output logic resetn
);

   initial begin
      clk    = 1'b0;
      resetn = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   initial begin
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
   end

endmodule

/* tb/csr_tb.sv */
`timescale 1ns/100ps

module csr_tb
   import csr_pkg::*, exc_pkg::*;
;

   localparam int TEST_CYCLES = 400;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic              clk;
   logic              resetn;
   csr_access_t       csr_req;
   exc_report_t       exc;
   logic [7:0]        hw_int;
   logic              ipi_int;
   logic [DATA_W-1:0] coreid;
   logic [DATA_W-1:0] csr_rvalue;
   logic [DATA_W-1:0] ex_entry;
   logic [DATA_W-1:0] era;
   logic              has_int;

   // Expected register state
   logic [DATA_W-1:0] ref_crmd, ref_prmd, ref_ecfg, ref_era, ref_eentry, ref_badv;
   logic [DATA_W-1:0] ref_tid, ref_tcfg, ref_tval;
   logic [DATA_W-1:0] ref_save [N_SAVE];
   logic [5:0]        ref_ecode;
   logic [8:0]        ref_esub;
   logic [1:0]        ref_is_sw;
   logic [7:0]        ref_hw;
   logic              ref_ipi, ref_is_timer;
   integer            seed;
   int                cycle_count;

   tb_clock #(.PERIOD(4.0), .RESET_CYCLES(5)) u_clock (.clk(clk), .resetn(resetn));

   csr_top DUT (
      .clk(clk), .resetn(resetn), .csr_req(csr_req), .exc(exc), .hw_int(hw_int),
      .ipi_int(ipi_int), .coreid(coreid), .csr_rvalue(csr_rvalue),
      .ex_entry(ex_entry), .era(era), .has_int(has_int)
   );

   function automatic logic [12:0] ref_is_vec();
      return {ref_ipi, ref_is_timer, 1'b0, ref_hw, ref_is_sw};
   endfunction

   function automatic logic [DATA_W-1:0] ref_read(input logic [CSR_NUM_W-1:0] num);
      case (num)
         CSR_CRMD:   return ref_crmd;
         CSR_PRMD:   return ref_prmd;
         CSR_ECFG:   return ref_ecfg;
         CSR_ESTAT:  return {1'b0, ref_esub, ref_ecode, 3'd0, ref_is_vec()};
         CSR_ERA:    return ref_era;
         CSR_BADV:   return ref_badv;
         CSR_EENTRY: return ref_eentry;
         CSR_SAVE0:  return ref_save[0];
         CSR_SAVE1:  return ref_save[1];
         CSR_SAVE2:  return ref_save[2];
         CSR_SAVE3:  return ref_save[3];
         CSR_TID:    return ref_tid;
         CSR_TCFG:   return ref_tcfg;
         CSR_TVAL:   return ref_tval;
         default:    return '0;
      endcase
   endfunction

   task automatic stop_on_mismatch(input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "first mismatch, run stopped");
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp)
         stop_on_mismatch($sformatf("%s got %08h expected %08h", what, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   task automatic read_check(input logic [CSR_NUM_W-1:0] num);
      @(posedge clk);
      csr_req <= '{re: 1'b1, num: num, we: 1'b0, wmask: '0, wvalue: '0};
      @(negedge clk);
      check_word(csr_rvalue, ref_read(num), $sformatf("read of csr %03h", num));
   endtask

   task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [DATA_W-1:0] v,
                            input logic [DATA_W-1:0] m);
      logic [DATA_W-1:0] merged;
      merged = (v & m) | (ref_read(num) & ~m);
      @(posedge clk);
      csr_req <= '{re: 1'b0, num: num, we: 1'b1, wmask: m, wvalue: v};
      @(posedge clk);
      // Read port left on TVAL so the timer can be watched straight away
      csr_req <= '{re: 1'b1, num: CSR_TVAL, we: 1'b0, wmask: '0, wvalue: '0};
      case (num)
         CSR_CRMD:   ref_crmd = merged & 32'h1ff;
         CSR_PRMD:   ref_prmd = merged & 32'h7;
         CSR_ECFG:   ref_ecfg = merged & 32'h1bff;
         CSR_ESTAT:  ref_is_sw = merged[1:0];
         CSR_ERA:    ref_era = merged;
         CSR_EENTRY: ref_eentry = merged & 32'hffff_ffc0;
         CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: ref_save[num - CSR_SAVE0] = merged;
         CSR_TID:    ref_tid = merged;
         CSR_TCFG: begin
            ref_tcfg = merged;
            if (merged[0]) ref_tval = {merged[31:2], 2'b00};
         end
         CSR_TICLR:  if (merged[0]) ref_is_timer = 1'b0;
         default: ;
      endcase
   endtask

   task automatic raise_exc(input logic ertn, input logic [DATA_W-1:0] pc,
                            input logic [DATA_W-1:0] va, input logic [5:0] code,
                            input logic [8:0] sub);
      @(posedge clk);
      exc <= '{ex: !ertn, ertn: ertn, pc: pc, vaddr: va, ecode: code, esubcode: sub};
      @(posedge clk);
      exc <= '0;
      if (ertn) begin
         ref_crmd[2:0] = ref_prmd[2:0];
      end else begin
         ref_prmd  = {29'd0, ref_crmd[2:0]};
         ref_crmd[2:0] = 3'd0;
         ref_era   = pc;
         ref_ecode = code;
         ref_esub  = sub;
         if (code == ECODE_ADE && sub == ESUB_ADEF) ref_badv = pc;
         else if (code == ECODE_ADE || code == ECODE_ALE) ref_badv = va;
      end
   endtask

   // Expects the read port on TVAL and the counter at first
   task automatic tval_run(input logic [DATA_W-1:0] first, input int steps);
      for (int k = 0; k <= steps; k++) begin
         if (k > 0) @(posedge clk);
         @(negedge clk);
         ref_tval = first - k;
         check_word(csr_rvalue, ref_read(CSR_TVAL), "TVAL countdown");
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      logic [CSR_NUM_W-1:0] nums [9];
      logic [7:0] hv;
      logic ip, ie;
      seed = 88;
      cycle_count = 0;
      csr_req = '0;
      exc = '0;
      hw_int = '0;
      ipi_int = 1'b0;
      coreid = 32'h0000_0003;
      ref_crmd = 32'h8;
      ref_prmd = '0;
      ref_ecfg = '0;
      ref_tcfg = '0;
      ref_tval = 32'hffff_ffff;
      ref_tid = coreid;
      ref_is_sw = '0;
      ref_hw = '0;
      ref_ipi = 1'b0;
      ref_is_timer = 1'b0;
      nums = '{CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_EENTRY, CSR_ECFG,
               CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};
      wait (resetn === 1'b1);

      read_check(CSR_CRMD);
      read_check(CSR_TVAL);
      read_check(CSR_TID);
      read_check(CSR_ECFG);
      read_check(CSR_TCFG);
      check_bit(has_int, 1'b0, "has_int after reset");

      // Registers without reset get a full write first
      for (int i = 2; i < 9; i++) write_csr(nums[i], $random(seed), 32'hffff_ffff);
      for (int i = 0; i < 24; i++) begin
         logic [CSR_NUM_W-1:0] n;
         n = nums[$unsigned($random(seed)) % 9];
         write_csr(n, $random(seed), $random(seed));
         read_check(n);
      end
      read_check(14'h3ff);

      write_csr(CSR_CRMD, 32'h7, 32'h7);
      raise_exc(1'b0, {$random(seed)} & ~32'h3, 32'h0, ECODE_ADE, ESUB_ADEF);
      read_check(CSR_CRMD);
      read_check(CSR_PRMD);
      read_check(CSR_ERA);
      read_check(CSR_ESTAT);
      read_check(CSR_BADV);
      check_word(ex_entry, ref_eentry, "ex_entry");
      check_word(era, ref_era, "era output");
      raise_exc(1'b1, '0, '0, '0, '0);
      read_check(CSR_CRMD);
      write_csr(CSR_CRMD, 32'h6, 32'h7);
      raise_exc(1'b0, $random(seed), $random(seed), ECODE_ALE, 9'd0);
      read_check(CSR_PRMD);
      read_check(CSR_ESTAT);
      read_check(CSR_BADV);
      raise_exc(1'b1, '0, '0, '0, '0);
      read_check(CSR_CRMD);

      // One-shot timer, initval 3
      write_csr(CSR_TCFG, {30'd3, 2'b01}, 32'hffff_ffff);
      tval_run(32'd12, 12);
      @(posedge clk);
      ref_is_timer = 1'b1;
      tval_run(32'hffff_ffff, 0);
      read_check(CSR_ESTAT);
      write_csr(CSR_TICLR, 32'h1, 32'h1);
      read_check(CSR_ESTAT);

      // Periodic timer, initval 2
      write_csr(CSR_TCFG, {30'd2, 2'b11}, 32'hffff_ffff);
      tval_run(32'd8, 8);
      @(posedge clk);
      ref_is_timer = 1'b1;
      tval_run(32'd8, 1);
      read_check(CSR_ESTAT);
      write_csr(CSR_TCFG, 32'h0, 32'hffff_ffff);
      write_csr(CSR_TICLR, 32'h1, 32'h1);
      read_check(CSR_ESTAT);

      // Timer bit pending while the interrupt loop starts
      write_csr(CSR_TCFG, {30'd1, 2'b01}, 32'hffff_ffff);
      repeat (6) @(posedge clk);
      ref_is_timer = 1'b1;
      for (int i = 0; i < 12; i++) begin
         hv = $random(seed);
         ip = $random(seed);
         ie = $random(seed);
         write_csr(CSR_ECFG, $random(seed), 32'hffff_ffff);
         write_csr(CSR_CRMD, {29'd0, ie, 2'd0}, 32'h4);
         if (i == 3) write_csr(CSR_ESTAT, $random(seed), 32'h3);
         if (i == 6) write_csr(CSR_TICLR, 32'h1, 32'h1);
         @(posedge clk);
         hw_int  <= hv;
         ipi_int <= ip;
         repeat (2) @(posedge clk);
         @(negedge clk);
         ref_hw  = hv;
         ref_ipi = ip;
         check_bit(has_int, ref_crmd[2] & (|(ref_is_vec() & ref_ecfg[12:0])), "has_int");
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

/* src.f */
logic/csr_pkg.sv
logic/exc_pkg.sv
logic/exc_state.sv
logic/int_timer.sv
logic/csr_scratch.sv
logic/csr_read_mux.sv
logic/csr_top.sv
tb/tb_clock.sv
tb/csr_tb.sv
